/* accumulate/addend_aligner.sv */
`timescale 1ns/1ns
`include "mac_cfg.svh"

module addend_aligner import fp_types_pkg::*, mac_pipe_pkg::*; (
    input  fp32_fields_t                c_i,
    input  logic signed [`MAC_EXP_W+1:0] prod_exp_i,
    input  logic                        prod_sign_i,
    output aligned_addend_t             addend_o
);

    localparam int W  = `MAC_WIN_W;
    localparam int EW = `MAC_EXP_W + 2;

    logic signed [EW-1:0] exp_diff;
    logic [EW-1:0]        shamt;
    logic                 c_zero;
    logic                 eff_sub;
    logic [W-1:0]         placed;
    logic [W-1:0]         shifted;

    // Zero whatever the sign bit says
    assign c_zero = (c_i.exp == '0) && (c_i.mant == '0);

    // Signs differ, zero addend never subtracts
    assign eff_sub = (c_i.sign ^ prod_sign_i) & ~c_zero;

    // Right shift distance into the product frame
    assign exp_diff = prod_exp_i - $signed({2'b00, c_i.exp});
    assign shamt    = exp_diff[EW-1] ? '0 : $unsigned(exp_diff);

    // Hidden bit lands on window bit 46
    assign placed  = {1'b0, |c_i.exp, c_i.mant, {(W - `MAC_MANT_W - 2){1'b0}}};
    // Bits falling off the bottom are dropped
    assign shifted = placed >> shamt;

    assign addend_o = '{
        win:  eff_sub ? ~shifted : shifted,
        sub:  eff_sub,
        zero: c_zero
    };

    // Addend exponent never above product exponent
    always_comb begin
        if (!c_zero) begin
            assert (!exp_diff[EW-1])
                else $error("addend exponent exceeds product exponent");
        end
    end

endmodule

/* accumulate/eac_adder.sv */
`timescale 1ns/1ns
`include "mac_cfg.svh"

module eac_adder (
    input  logic [`MAC_WIN_W-1:0] csa_sum_i,
    input  logic [`MAC_WIN_W-1:0] csa_carry_i,
    input  logic                  carry_postcor_i,
    input  logic                  sub_sign_i,
    input  logic                  a_zero_i,
    output logic [`MAC_WIN_W-1:0] low_sum_o,
    output logic                  low_carry_o,
    output logic [`MAC_WIN_W-1:0] low_sum_inv_o,
    output logic                  low_carry_inv_o
);

    localparam int W = `MAC_WIN_W;

    logic         eac;
    logic [W:0]   carry_vec;
    logic [W:0]   fwd;
    logic [W:0]   neg;

    // End-around carry only for a real subtraction
    assign eac = sub_sign_i & ~a_zero_i;

    // Carry vector at its true weight, folded carry on top, EAC in the hole
    assign carry_vec = {carry_postcor_i, csa_carry_i[W-2:0], eac};

    // True sum
    assign fwd = {1'b0, csa_sum_i} + carry_vec;

    // Two's complement negation, built from the inverted vectors
    // Two +1 terms, one per inverted operand
    assign neg = {1'b1, ~csa_sum_i} + ~carry_vec + (W+1)'(2);

    assign {low_carry_o, low_sum_o}         = fwd;
    assign {low_carry_inv_o, low_sum_inv_o} = neg;

endmodule

/* accumulate/mant_product_tree.sv */
`timescale 1ns/1ns
`include "mac_cfg.svh"

module mant_product_tree import mac_pipe_pkg::*; (
    input  logic [`MAC_MANT_W:0]  mant_a_i,
    input  logic [`MAC_MANT_W:0]  mant_b_i,
    input  aligned_addend_t       addend_i,
    output logic [`MAC_WIN_W-1:0] csa_sum_o,
    output logic [`MAC_WIN_W-1:0] csa_carry_o,
    output logic                  carry_postcor_o
);

    localparam int MW   = `MAC_MANT_W + 1;
    localparam int W    = `MAC_WIN_W;
    // One guard column above the window
    localparam int TW   = W + 1;
    // Addend and pp0 enter row 0, one more pp per row
    localparam int ROWS = MW - 1;

    logic [TW-1:0] pp    [MW];
    logic [TW-1:0] row_s [ROWS+1];
    logic [TW-1:0] row_c [ROWS+1];

    genvar j;
    genvar k;

    //////////////////////////////////////////////////////////////////////
    // Partial products
    //////////////////////////////////////////////////////////////////////

    generate
        for (j = 0; j < MW; j++) begin : g_pp
            // AND row, shifted to its weight
            assign pp[j] = TW'(mant_a_i & {MW{mant_b_i[j]}}) << j;
        end
    endgenerate

    //////////////////////////////////////////////////////////////////////
    // Linear chain of 3:2 rows
    //////////////////////////////////////////////////////////////////////

    // Row 0 inputs
    assign row_s[0] = {1'b0, addend_i.win};
    assign row_c[0] = pp[0];

    generate
        for (k = 0; k < ROWS; k++) begin : g_row
            logic [TW-1:0] maj;
            // Full adder per column
            assign row_s[k+1] = row_s[k] ^ row_c[k] ^ pp[k+1];
            assign maj        = (row_s[k] & row_c[k]) | (row_s[k] & pp[k+1]) |
                                (row_c[k] & pp[k+1]);
            // Carries move up one column, weight 2^49 drops out
            assign row_c[k+1] = {maj[TW-2:0], 1'b0};
        end
    endgenerate

    // Sum vector as is
    assign csa_sum_o   = row_s[ROWS][W-1:0];
    // Carry vector back to one bit below its weight
    assign csa_carry_o = row_c[ROWS][W:1];
    // Two bits of weight 2^48 fold to one, modulo 2^49
    assign carry_postcor_o = row_s[ROWS][W] ^ row_c[ROWS][W];

endmodule

/* accumulate/normalize_pack.sv */
`timescale 1ns/1ns
`include "mac_cfg.svh"

module normalize_pack import fp_types_pkg::*; (
    input  logic [`MAC_WIN_W-1:0]        low_sum_i,
    input  logic                         low_carry_i,
    input  logic [`MAC_WIN_W-1:0]        low_sum_inv_i,
    input  logic                         low_carry_inv_i,
    input  logic                         sub_sign_i,
    input  logic                         prod_sign_i,
    input  logic signed [`MAC_EXP_W+1:0] prod_exp_i,
    output fp32_word_t                   result_o
);

    // Magnitude has one carry bit above the window
    localparam int MAG_W = `MAC_WIN_W + 1;
    localparam int EW    = `MAC_EXP_W + 2;
    localparam int LZ_W  = $clog2(MAG_W);
    // Binary point at bit 46, leading one normalized to bit 48
    localparam logic signed [EW-1:0] EXP_OFS = EW'(2);

    logic                 use_inv;
    logic                 res_sign;
    logic [MAG_W-1:0]     mag;
    logic [MAG_W-1:0]     norm;
    logic [LZ_W-1:0]      lz;
    logic signed [EW-1:0] res_exp;

    //////////////////////////////////////////////////////////////////////
    // Magnitude and sign select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // No carry out on subtract means addend won
        use_inv = sub_sign_i & ~low_carry_i;
        if (use_inv) begin
            // Negation of a nonzero value below 2^48 always carries out
            mag = {~low_carry_inv_i, low_sum_inv_i};
        end else begin
            // Carry is magnitude only on effective add
            mag = {low_carry_i & ~sub_sign_i, low_sum_i};
        end
        res_sign = prod_sign_i ^ use_inv;
    end

    //////////////////////////////////////////////////////////////////////
    // Leading zero count and shift
    //////////////////////////////////////////////////////////////////////

    // Highest set bit wins
    always_comb begin
        lz = '0;
        for (int i = 0; i < MAG_W; i++) begin
            if (mag[i]) begin
                lz = LZ_W'(MAG_W - 1 - i);
            end
        end
    end

    assign norm    = mag << lz;
    assign res_exp = prod_exp_i + EXP_OFS - $signed({{(EW - LZ_W){1'b0}}, lz});

    // Pack, truncating below 23 fraction bits
    always_comb begin
        result_o.raw = '0;
        // Cancellation gives +0
        if (|mag) begin
            result_o.f.sign = res_sign;
            result_o.f.exp  = res_exp[`MAC_EXP_W-1:0];
            result_o.f.mant = norm[MAG_W-2 -: `MAC_MANT_W];
        end
    end

    // LZC and shifter agree
    always_comb begin
        if (|mag) begin
            assert (norm[MAG_W-1]) else $error("normalized magnitude lacks leading one");
        end
    end

endmodule

/* common/fp_types_pkg.sv */
`include "mac_cfg.svh"

package fp_types_pkg;

    //////////////////////////////////////////////////////////////////////
    // binary32 word views
    //////////////////////////////////////////////////////////////////////

    // Field view, msb first
    typedef struct packed {
        // Sign bit
        logic                   sign;
        // Biased exponent
        logic [`MAC_EXP_W-1:0]  exp;
        // Fraction without hidden bit
        logic [`MAC_MANT_W-1:0] mant;
    } fp32_fields_t;

    // Same 32 bits decoded two ways
    typedef union packed {
        // Raw word for compare and clear
        logic [`MAC_EXP_W+`MAC_MANT_W:0] raw;
        // Sign, exponent, fraction
        fp32_fields_t                    f;
    } fp32_word_t;

endpackage

/* common/mac_cfg.svh */
`ifndef MAC_CFG_SVH
`define MAC_CFG_SVH

// Stored fraction bits of binary32
`define MAC_MANT_W 23

// Biased exponent field width
`define MAC_EXP_W 8

// Exponent bias
`define MAC_BIAS 127

// Carry-save window
// Two hidden-bit mantissas side by side, binary point at bit 46
`define MAC_WIN_W (2 * `MAC_MANT_W + 2)

`endif

/* common/mac_pipe_pkg.sv */
`include "mac_cfg.svh"

package mac_pipe_pkg;

    //////////////////////////////////////////////////////////////////////
    // Stage 1 datapath bundles
    //////////////////////////////////////////////////////////////////////

    // Addend after alignment into the product window
    typedef struct packed {
        // Window bits, already inverted for effective subtract
        logic [`MAC_WIN_W-1:0] win;
        // Effective subtract
        logic                  sub;
        // Addend is +0 or -0
        logic                  zero;
    } aligned_addend_t;

    // Stage 1 register contents
    typedef struct packed {
        // Carry-save pair, carry vector one bit left of its weight
        logic [`MAC_WIN_W-1:0] sum;
        logic [`MAC_WIN_W-1:0] carry;
        // Folded weight-2^48 bit of the tree
        logic                  cpc;
        logic                  sub;
        logic                  zero;
        // Product sign and biased exponent with signed margin
        logic                  sign;
        logic [`MAC_EXP_W+1:0] exp;
        logic                  valid;
    } csa_stage_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build and run the MAC testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module mac_tb \
    -Mdir obj_dir \
    -o Vmac_tb

# The log decides pass or fail
./obj_dir/Vmac_tb 2>&1 | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* source/mac_top.sv */
`timescale 1ns/1ns
`include "mac_cfg.svh"

module mac_top import fp_types_pkg::*, mac_pipe_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       valid_i,
    input  fp32_word_t a_i,
    input  fp32_word_t b_i,
    input  fp32_word_t c_i,
    output logic       valid_o,
    output fp32_word_t result_o
);

    localparam int MW = `MAC_MANT_W + 1;
    localparam int W  = `MAC_WIN_W;
    localparam int EW = `MAC_EXP_W + 2;
    localparam logic signed [EW-1:0] BIAS = EW'(`MAC_BIAS);

    fp32_fields_t         a_f;
    fp32_fields_t         b_f;
    logic [MW-1:0]        mant_a;
    logic [MW-1:0]        mant_b;
    logic                 prod_sign;
    logic signed [EW-1:0] prod_exp;
    aligned_addend_t      addend;
    logic [W-1:0]         csa_sum;
    logic [W-1:0]         csa_carry;
    logic                 carry_postcor;
    csa_stage_t           st1_q;
    logic [W-1:0]         low_sum;
    logic [W-1:0]         low_sum_inv;
    logic                 low_carry;
    logic                 low_carry_inv;
    fp32_word_t           res_word;
    fp32_word_t           result_q;
    logic                 valid_q;

    //////////////////////////////////////////////////////////////////////
    // Stage 1 unpacks and reduces to carry-save
    //////////////////////////////////////////////////////////////////////

    assign a_f = a_i.f;
    assign b_f = b_i.f;

    // Hidden bit from nonzero exponent
    assign mant_a = {|a_f.exp, a_f.mant};
    assign mant_b = {|b_f.exp, b_f.mant};

    assign prod_sign = a_f.sign ^ b_f.sign;
    // Biased sum with one bias removed
    assign prod_exp  = $signed({2'b00, a_f.exp}) + $signed({2'b00, b_f.exp}) - BIAS;

    addend_aligner u_addend_aligner (
        .c_i         (c_i.f),
        .prod_exp_i  (prod_exp),
        .prod_sign_i (prod_sign),
        .addend_o    (addend)
    );

    mant_product_tree u_mant_product_tree (
        .mant_a_i        (mant_a),
        .mant_b_i        (mant_b),
        .addend_i        (addend),
        .csa_sum_o       (csa_sum),
        .csa_carry_o     (csa_carry),
        .carry_postcor_o (carry_postcor)
    );

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            st1_q <= '0;
        end else begin
            st1_q <= '{
                sum:   csa_sum,
                carry: csa_carry,
                cpc:   carry_postcor,
                sub:   addend.sub,
                zero:  addend.zero,
                sign:  prod_sign,
                exp:   prod_exp,
                valid: valid_i
            };
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 2 resolves, normalizes and packs
    //////////////////////////////////////////////////////////////////////

    eac_adder u_eac_adder (
        .csa_sum_i       (st1_q.sum),
        .csa_carry_i     (st1_q.carry),
        .carry_postcor_i (st1_q.cpc),
        .sub_sign_i      (st1_q.sub),
        .a_zero_i        (st1_q.zero),
        .low_sum_o       (low_sum),
        .low_carry_o     (low_carry),
        .low_sum_inv_o   (low_sum_inv),
        .low_carry_inv_o (low_carry_inv)
    );

    normalize_pack u_normalize_pack (
        .low_sum_i       (low_sum),
        .low_carry_i     (low_carry),
        .low_sum_inv_i   (low_sum_inv),
        .low_carry_inv_i (low_carry_inv),
        .sub_sign_i      (st1_q.sub),
        .prod_sign_i     (st1_q.sign),
        .prod_exp_i      (st1_q.exp),
        .result_o        (res_word)
    );

    // Output register holds the word between results
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q  <= 1'b0;
            result_q <= '0;
        end else begin
            valid_q <= st1_q.valid;
            if (st1_q.valid) begin
                result_q <= res_word;
            end
        end
    end

    assign valid_o  = valid_q;
    assign result_o = result_q;

    // Both pipeline stages flushed by reset
    a_no_valid_after_reset: assert property (@(posedge clk_i)
        (!rst_n_i || $past(!rst_n_i)) |=> !valid_o)
        else $error("valid_o high within two cycles after reset");

endmodule

/* verification/mac_tb.sv */
`timescale 1ns/1ns
`include "mac_cfg.svh"

module mac_tb import fp_types_pkg::*; ();

    localparam int CLK_NS     = 4;
    localparam int N_DIRECTED = 13;
    localparam int N_STREAM   = 200;
    // Up to 6 cycles per directed op and one per stream op
    localparam int WATCHDOG_NS = (N_DIRECTED * 6 + N_STREAM + 20) * CLK_NS + 400;

    logic        clk_i;
    logic        rst_n_i;
    logic        valid_i;
    fp32_word_t  a_i;
    fp32_word_t  b_i;
    fp32_word_t  c_i;
    logic        valid_o;
    fp32_word_t  result_o;

    // Expected results in issue order
    fp32_word_t  exp_q[$];
    int unsigned lcg_state;
    int          results_checked;

    mac_top u_mac_top (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .valid_i  (valid_i),
        .a_i      (a_i),
        .b_i      (b_i),
        .c_i      (c_i),
        .valid_o  (valid_o),
        .result_o (result_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_NS / 2) clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////////////////////////
    // Error reporting and compares
    //////////////////////////////////////////////////////////////////////

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input fp32_word_t got, input fp32_word_t exp);
        if (got.raw !== exp.raw) begin
            stop_on_error($sformatf("CHECK FAILED %s got 0x%08h expected 0x%08h",
                                    name, got.raw, exp.raw));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h",
                                    name, got, exp));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers and reference model
    //////////////////////////////////////////////////////////////////////

    function automatic fp32_word_t word_of(input logic [31:0] bits);
        fp32_word_t w;
        w.raw = bits;
        return w;
    endfunction

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Normal factor with exponent 110..141
    function automatic fp32_word_t rand_factor();
        int unsigned r;
        int unsigned m;
        fp32_word_t  w;
        r = lcg_next();
        m = lcg_next();
        w.f.sign = r[31];
        w.f.exp  = 8'(110 + int'((r >> 24) % 32));
        w.f.mant = m[30:8];
        return w;
    endfunction

    // Addend at or below the product exponent and now and then a signed zero
    function automatic fp32_word_t rand_addend(input int pe);
        int unsigned r;
        int unsigned m;
        fp32_word_t  w;
        r = lcg_next();
        m = lcg_next();
        w.f.sign = r[31];
        w.f.exp  = 8'(pe - int'((r >> 20) % 28));
        w.f.mant = m[30:8];
        if (((r >> 12) % 16) == 0) begin
            w.f.exp  = '0;
            w.f.mant = '0;
        end
        return w;
    endfunction

    // Integer model of product, truncated addend, sign pick and normalize
    function automatic fp32_word_t ref_mac(input fp32_word_t a, input fp32_word_t b,
                                           input fp32_word_t c);
        longint unsigned ma;
        longint unsigned mb;
        longint unsigned prod;
        longint unsigned cm;
        longint unsigned aligned;
        longint unsigned mag;
        int              pe;
        int              shamt;
        int              p;
        logic            sign;
        logic            sub;
        logic            czero;
        fp32_word_t      r;
        ma    = 64'({1'b1, a.f.mant});
        mb    = 64'({1'b1, b.f.mant});
        prod  = ma * mb;
        pe    = int'(a.f.exp) + int'(b.f.exp) - `MAC_BIAS;
        sign  = a.f.sign ^ b.f.sign;
        czero = (c.f.exp == 0) && (c.f.mant == 0);
        sub   = (c.f.sign != sign) && !czero;
        aligned = 0;
        if (!czero) begin
            // Hidden bit at bit 46 like the product's binary point
            cm    = 64'({1'b1, c.f.mant});
            cm    = cm << 23;
            shamt = pe - int'(c.f.exp);
            aligned = (shamt > 47) ? 64'd0 : (cm >> shamt);
        end
        if (!sub) begin
            mag = prod + aligned;
        end else if (prod >= aligned) begin
            mag = prod - aligned;
        end else begin
            mag  = aligned - prod;
            sign = ~sign;
        end
        r.raw = '0;
        if (mag != 0) begin
            p = 0;
            for (int i = 0; i < 49; i++) begin
                if (mag[i]) begin
                    p = i;
                end
            end
            r.f.sign = sign;
            r.f.exp  = 8'(pe + p - 46);
            // Hidden bit drops out with the 23-bit cut
            if (p >= 23) begin
                r.f.mant = 23'(mag >> (p - 23));
            end else begin
                r.f.mant = 23'(mag << (23 - p));
            end
        end
        return r;
    endfunction

    // One sample 1 ns after the edge
    task automatic drive_op(input fp32_word_t a, input fp32_word_t b, input fp32_word_t c);
        @(posedge clk_i);
        #1;
        valid_i = 1'b1;
        a_i     = a;
        b_i     = b;
        c_i     = c;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
            n++;
            if (n > 8) begin
                stop_on_error("pipeline did not return all pending results within 8 cycles");
            end
        end
    endtask

    task automatic run_one(input logic [31:0] a, input logic [31:0] b, input logic [31:0] c,
                           input logic [31:0] exp);
        drive_op(word_of(a), word_of(b), word_of(c));
        exp_q.push_back(word_of(exp));
        @(posedge clk_i);
        #1;
        valid_i = 1'b0;
        wait_drain();
    endtask

    // In-order output monitor on the falling edge
    always @(negedge clk_i) begin
        if (valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                stop_on_error("valid_o went high with no result pending");
            end else begin
                check_word("result_o", result_o, exp_q.pop_front());
                results_checked++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset_and_latency();
        fp32_word_t zero_w;
        zero_w = word_of(32'h0);
        repeat (3) begin
            @(posedge clk_i);
            #1;
            check_bit("valid_o", valid_o, 1'b0);
            check_word("result_o", result_o, zero_w);
        end
        rst_n_i = 1'b1;
        @(posedge clk_i);
        #1;
        check_bit("valid_o", valid_o, 1'b0);
        check_word("result_o", result_o, zero_w);
        // Single pulse 1.5 * 2.0 + 1.0
        drive_op(word_of(32'h3FC00000), word_of(32'h40000000), word_of(32'h3F800000));
        exp_q.push_back(word_of(32'h40800000));
        @(posedge clk_i);
        #1;
        valid_i = 1'b0;
        check_bit("valid_o", valid_o, 1'b0);
        // Result two edges after the drive edge
        @(posedge clk_i);
        #1;
        check_bit("valid_o", valid_o, 1'b1);
        @(posedge clk_i);
        #1;
        check_bit("valid_o", valid_o, 1'b0);
        if (exp_q.size() != 0) begin
            stop_on_error("single pulse result was not returned");
        end
    endtask

    task automatic test_effective_add();
        run_one(32'h3FC00000, 32'h40000000, 32'h3F800000, 32'h40800000);
        // -3.0 * 2.0 - 0.5
        run_one(32'hC0400000, 32'h40000000, 32'hBF000000, 32'hC0D00000);
        // 2.25 + 1.75 lands on bit 48
        run_one(32'h3FC00000, 32'h3FC00000, 32'h3FE00000, 32'h40800000);
    endtask

    task automatic test_effective_sub();
        // Product larger in 6.0 - 1.0
        run_one(32'h40400000, 32'h40000000, 32'hBF800000, 32'h40A00000);
        // Same exponent where the addend wins and the sign flips
        run_one(32'h3FA00000, 32'h3F800000, 32'hBFE00000, 32'hBF000000);
        run_one(32'h3F800000, 32'h3FC00000, 32'hBFE00000,
                ref_mac(word_of(32'h3F800000), word_of(32'h3FC00000),
                        word_of(32'hBFE00000)));
    endtask

    task automatic test_zero_and_cancel();
        run_one(32'h3FC00000, 32'h40000000, 32'h00000000, 32'h40400000);
        run_one(32'h3FC00000, 32'h40000000, 32'h80000000, 32'h40400000);
        // Negative product with +0 and differing signs
        run_one(32'hBFC00000, 32'h40000000, 32'h00000000, 32'hC0400000);
        // Full-width product shows any off-by-one in the low bits
        run_one(32'h3FAAAAAB, 32'h40490FDB, 32'h80000000,
                ref_mac(word_of(32'h3FAAAAAB), word_of(32'h40490FDB),
                        word_of(32'h80000000)));
        // Exact cancellation for both product signs
        run_one(32'h3FC00000, 32'h40000000, 32'hC0400000, 32'h00000000);
        run_one(32'hBFC00000, 32'h40000000, 32'h40400000, 32'h00000000);
    endtask

    task automatic test_streaming();
        fp32_word_t a;
        fp32_word_t b;
        fp32_word_t c;
        int         pe;
        for (int i = 0; i < N_STREAM; i++) begin
            a  = rand_factor();
            b  = rand_factor();
            pe = int'(a.f.exp) + int'(b.f.exp) - `MAC_BIAS;
            c  = rand_addend(pe);
            drive_op(a, b, c);
            exp_q.push_back(ref_mac(a, b, c));
        end
        @(posedge clk_i);
        #1;
        valid_i = 1'b0;
        wait_drain();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst_n_i   = 1'b0;
        valid_i   = 1'b0;
        a_i.raw   = '0;
        b_i.raw   = '0;
        c_i.raw   = '0;
        lcg_state = 32'd91;
        results_checked = 0;
        test_reset_and_latency();
        test_effective_add();
        test_effective_sub();
        test_zero_and_cancel();
        test_streaming();
        repeat (2) @(posedge clk_i);
        if (results_checked == N_DIRECTED + N_STREAM) begin
            $display("TEST PASS");
            $finish;
        end else begin
            stop_on_error($sformatf("%0d results were checked where %0d were expected",
                                    results_checked, N_DIRECTED + N_STREAM));
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_on_error("timeout: the run did not finish within the watchdog limit");
    end

endmodule

/* vlog.f */
+incdir+common
common/fp_types_pkg.sv
common/mac_pipe_pkg.sv
accumulate/addend_aligner.sv
accumulate/mant_product_tree.sv
accumulate/eac_adder.sv
accumulate/normalize_pack.sv
source/mac_top.sv
verification/mac_tb.sv
